// ==== common/fpuCtrlPkg.sv ====
// fpu control package
// vector types and packed control words shared by decoder, enables and pipeline

`default_nettype none

package fpuCtrlPkg;

  ////////////////////////////////////////////////////////////////////////////
  // plain vectors with a meaning
  typedef logic [2:0] opCtrl_t;       // op select inside each fpu unit
  typedef logic [1:0] resSel_t;       // final result source
  typedef logic [1:0] postProcSel_t;  // 00 cvt, 01 div, 10 fma
  typedef logic [2:0] roundMode_t;    // rne rtz rdn rup rmm
  typedef logic       fpFmt_t;        // 0 single, 1 double
  typedef logic [4:0] regAdr_t;       // fp register number

  ////////////////////////////////////////////////////////////////////////////
  // decoder raw output, field order matches the table literals
  typedef struct packed {
    logic         fRegWrite;    // write fp regfile
    logic         fWriteInt;    // write int regfile
    resSel_t      resSel;
    postProcSel_t postProcSel;
    opCtrl_t      opCtrl;
    logic         fdivStart;    // div or sqrt
    logic         illegal;
    logic         cvtInt;       // fp -> int conversion
  } decodeCtrl_t;

  // execute and memory stage controls
  typedef struct packed {
    logic         fRegWrite;
    logic         fWriteInt;
    resSel_t      resSel;
    postProcSel_t postProcSel;
    opCtrl_t      opCtrl;
    roundMode_t   frm;          // resolved, never dyn
    fpFmt_t       fmt;
    logic         cvtInt;
    logic         fpuActive;    // legal fp op in flight
  } exCtrl_t;

  // writeback only needs these
  typedef struct packed {
    logic    fRegWrite;
    resSel_t resSel;
    logic    cvtInt;
  } wbCtrl_t;

  typedef struct packed {
    regAdr_t adr1;   // rs1
    regAdr_t adr2;   // rs2
    regAdr_t adr3;   // rs3, fma only
  } regAddrs_t;

  // unpacker source enables
  typedef struct packed {
    logic xEn;
    logic yEn;
    logic zEn;
  } srcEn_t;

  // host pipeline stall/flush per stage
  typedef struct packed {
    logic stallE;
    logic stallM;
    logic stallW;
    logic flushE;
    logic flushM;
    logic flushW;
  } pipeCtrl_t;

endpackage

`default_nettype wire

// ==== common/fpuCtrl_consts.svh ====
// fpu control constants
// opcodes, funct5 groups, rounding, format and status codes for the F/D decoder

`ifndef FPU_CTRL_CONSTS_SVH
`define FPU_CTRL_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// major opcodes
`define FP_OPC_LOAD    7'b0000111   // flw, fld
`define FP_OPC_STORE   7'b0100111   // fsw, fsd
`define FP_OPC_MADD    7'b1000011
`define FP_OPC_MSUB    7'b1000111
`define FP_OPC_NMSUB   7'b1001011
`define FP_OPC_NMADD   7'b1001111
`define FP_OPC_OP      7'b1010011   // everything else, split by funct5

// load/store width in funct3
`define LS_WIDTH_W     3'b010
`define LS_WIDTH_D     3'b011

////////////////////////////////////////////////////////////////////////////
// funct5 = funct7[6:2] under FP_OPC_OP, funct7[1:0] is the format
`define F5_ADD         5'b00000
`define F5_SUB         5'b00001
`define F5_MUL         5'b00010
`define F5_DIV         5'b00011
`define F5_SGNJ        5'b00100
`define F5_MINMAX      5'b00101
`define F5_CVT_FF      5'b01000     // fcvt.s.d / fcvt.d.s
`define F5_SQRT        5'b01011
`define F5_CMP         5'b10100     // fle, flt, feq
`define F5_CVT_FI      5'b11000     // fp -> int
`define F5_CVT_IF      5'b11010     // int -> fp
`define F5_MVXF_CLASS  5'b11100     // fmv.x.* and fclass share this
`define F5_MVFX        5'b11110

////////////////////////////////////////////////////////////////////////////
// rounding field, format and FS status
`define RM_RSV5        3'b101
`define RM_RSV6        3'b110
`define RM_DYN         3'b111       // take mode from frm csr
`define FMT_SINGLE     1'b0
`define FMT_DOUBLE     1'b1
`define FS_OFF         2'b00        // fpu disabled in mstatus

`endif

// ==== fpuCtrl/ctrlPipe.sv ====
// fpu control pipeline
// D/E, E/M and M/W control registers with per-stage stall and flush,
// plus the divider start that keeps moving while the divider is busy

`timescale 1ns/10ps
`default_nettype none

module ctrlPipe import fpuCtrlPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  pipeCtrl_t   pipe,
  input  decodeCtrl_t ctrlD,
  input  roundMode_t  frmD,
  input  fpFmt_t      fmtD,
  input  regAddrs_t   regAddrD,
  input  srcEn_t      srcEnD,
  input  logic        fdivBusyE,
  output exCtrl_t     exCtrlE,
  output regAddrs_t   regAddrE,
  output srcEn_t      srcEnE,
  output logic        fdivStartE,
  output exCtrl_t     memCtrlM,
  output wbCtrl_t     wbCtrlW
);

  exCtrl_t exCtrlD;     // decode values in E layout
  wbCtrl_t wbCtrlM;     // M values trimmed for writeback
  logic    divStartEn;

  always_comb begin
    exCtrlD.fRegWrite   = ctrlD.fRegWrite;
    exCtrlD.fWriteInt   = ctrlD.fWriteInt;
    exCtrlD.resSel      = ctrlD.resSel;
    exCtrlD.postProcSel = ctrlD.postProcSel;
    exCtrlD.opCtrl      = ctrlD.opCtrl;
    exCtrlD.frm         = frmD;
    exCtrlD.fmt         = fmtD;
    exCtrlD.cvtInt      = ctrlD.cvtInt;
    exCtrlD.fpuActive   = ~ctrlD.illegal;  // legal fp op entering E
  end

  ////////////////////////////////////////////////////////////////////////////
  // D/E
  always_ff @(posedge clk) begin
    if (rst) begin
      exCtrlE  <= '0;
      regAddrE <= '0;
      srcEnE   <= '0;
    end else if (!pipe.stallE) begin  // stall wins over flush
      if (pipe.flushE) begin
        exCtrlE  <= '0;
        regAddrE <= '0;
        srcEnE   <= '0;
      end else begin
        exCtrlE  <= exCtrlD;
        regAddrE <= regAddrD;
        srcEnE   <= srcEnD;
      end
    end
  end

  // busy divider keeps pulling the start bit even when E is stalled
  assign divStartEn = !pipe.stallE || fdivBusyE;

  always_ff @(posedge clk) begin
    if (rst)
      fdivStartE <= 1'b0;
    else if (divStartEn)
      fdivStartE <= pipe.flushE ? 1'b0 : ctrlD.fdivStart;
  end

  ////////////////////////////////////////////////////////////////////////////
  // E/M, fpuActive just rides along
  always_ff @(posedge clk) begin
    if (rst)
      memCtrlM <= '0;
    else if (!pipe.stallM) begin
      if (pipe.flushM)
        memCtrlM <= '0;
      else
        memCtrlM <= exCtrlE;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // M/W
  assign wbCtrlM.fRegWrite = memCtrlM.fRegWrite;
  assign wbCtrlM.resSel    = memCtrlM.resSel;
  assign wbCtrlM.cvtInt    = memCtrlM.cvtInt;

  always_ff @(posedge clk) begin
    if (rst)
      wbCtrlW <= '0;
    else if (!pipe.stallW) begin
      if (pipe.flushW)
        wbCtrlW <= '0;
      else
        wbCtrlW <= wbCtrlM;
    end
  end

  // nothing counts as an active fp op right out of reset
  assert property (@(posedge clk) rst |=> !exCtrlE.fpuActive && !memCtrlM.fpuActive)
    else $error("ctrlPipe: fpuActive set in E or M after reset");

endmodule

`default_nettype wire

// ==== fpuCtrl/fpuDecoder.sv ====
// fpu decoder
// checks legality, maps the instruction to a control word,
// resolves the rounding mode and picks single/double

`timescale 1ns/10ps
`default_nettype none

`include "fpuCtrl_consts.svh"

module fpuDecoder import fpuCtrlPkg::*; (
  input  logic [31:0] instr,
  input  roundMode_t  frmReg,     // frm csr
  input  logic [1:0]  fsStatus,   // mstatus.fs
  output decodeCtrl_t ctrl,
  output roundMode_t  frm,
  output fpFmt_t      fmt
);

  // fRegWrite_fWriteInt_resSel_postProcSel_opCtrl_fdivStart_illegal_cvtInt
  localparam decodeCtrl_t illegalCtrl = 12'b0_0_00_00_000_0_1_0;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] funct5;
  logic [1:0] fmtField;
  logic [4:0] rs2;
  logic       isLoadStore;
  logic       isCvtFF;
  logic       fmtOk;
  logic       rmOk;
  logic       fieldsOk;
  logic       cvtFfOk;

  ////////////////////////////////////////////////////////////////////////////
  // field slicing
  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];   // also the static rounding mode
  assign rs2      = instr[24:20];   // sub-opcode for cvt/sqrt/mv/class
  assign funct5   = instr[31:27];
  assign fmtField = instr[26:25];

  assign isLoadStore = (opcode == `FP_OPC_LOAD) || (opcode == `FP_OPC_STORE);
  assign isCvtFF     = (opcode == `FP_OPC_OP) && (funct5 == `F5_CVT_FF);

  // only s and d exist here, half/quad encodings trap
  assign fmtOk = ~fmtField[1];

  // 5 and 6 reserved; dyn is reserved too when frm itself is 5..7
  assign rmOk = !((funct3 == `RM_RSV5) || (funct3 == `RM_RSV6) ||
                  ((funct3 == `RM_DYN) && (frmReg >= `RM_RSV5)));

  // loads/stores carry width and imm in these fields, so skip the checks
  assign fieldsOk = (fsStatus != `FS_OFF) && (isLoadStore || (fmtOk && rmOk));

  // fp->fp cvt needs the other precision as source
  assign cvtFfOk = (rs2[4:1] == 4'b0000) &&
                   ((fmtField[0] == `FMT_DOUBLE) ? (rs2[0] == `FMT_SINGLE)
                                                 : (rs2[0] == `FMT_DOUBLE));

  ////////////////////////////////////////////////////////////////////////////
  // control word table
  always_comb begin
    ctrl = illegalCtrl;  // anything not matched below traps
    if (fieldsOk) begin
      case (opcode)
        `FP_OPC_LOAD:
          if (funct3 == `LS_WIDTH_W || funct3 == `LS_WIDTH_D)
            ctrl = 12'b1_0_10_00_000_0_0_0;              // flw/fld
        `FP_OPC_STORE:
          if (funct3 == `LS_WIDTH_W || funct3 == `LS_WIDTH_D)
            ctrl = 12'b0_0_10_00_000_0_0_0;              // fsw/fsd
        `FP_OPC_MADD:  ctrl = 12'b1_0_01_10_000_0_0_0;
        `FP_OPC_MSUB:  ctrl = 12'b1_0_01_10_001_0_0_0;
        `FP_OPC_NMSUB: ctrl = 12'b1_0_01_10_010_0_0_0;
        `FP_OPC_NMADD: ctrl = 12'b1_0_01_10_011_0_0_0;
        `FP_OPC_OP:
          case (funct5)
            `F5_ADD: ctrl = 12'b1_0_01_10_110_0_0_0;
            `F5_SUB: ctrl = 12'b1_0_01_10_111_0_0_0;
            `F5_MUL: ctrl = 12'b1_0_01_10_100_0_0_0;   // z operand unused
            `F5_DIV: ctrl = 12'b1_0_01_01_000_1_0_0;
            `F5_SQRT:
              if (rs2 == 5'b00000) ctrl = 12'b1_0_01_01_001_1_0_0;
            `F5_SGNJ:
              case (funct3)
                3'b000:  ctrl = 12'b1_0_00_00_000_0_0_0;  // fsgnj
                3'b001:  ctrl = 12'b1_0_00_00_001_0_0_0;  // fsgnjn
                3'b010:  ctrl = 12'b1_0_00_00_010_0_0_0;  // fsgnjx
                default: ;
              endcase
            `F5_MINMAX:
              case (funct3)
                3'b000:  ctrl = 12'b1_0_00_00_110_0_0_0;  // fmin
                3'b001:  ctrl = 12'b1_0_00_00_101_0_0_0;  // fmax
                default: ;
              endcase
            `F5_CMP:
              case (funct3)
                3'b000:  ctrl = 12'b0_1_00_00_011_0_0_0;  // fle
                3'b001:  ctrl = 12'b0_1_00_00_001_0_0_0;  // flt
                3'b010:  ctrl = 12'b0_1_00_00_010_0_0_0;  // feq
                default: ;
              endcase
            `F5_MVXF_CLASS:
              if (rs2 == 5'b00000 && funct3 == 3'b001)
                ctrl = 12'b0_1_10_00_000_0_0_0;           // fclass
              else if (rs2 == 5'b00000 && funct3 == 3'b000)
                ctrl = 12'b0_1_11_00_000_0_0_0;           // fmv.x.w/d
            `F5_MVFX:
              if (rs2 == 5'b00000 && funct3 == 3'b000)
                ctrl = 12'b1_0_00_00_011_0_0_0;           // fmv.w/d.x
            `F5_CVT_FF:
              // opCtrl carries the destination format
              if (cvtFfOk)
                ctrl = fmtField[0] ? 12'b1_0_01_00_001_0_0_0    // fcvt.d.s
                                   : 12'b1_0_01_00_000_0_0_0;   // fcvt.s.d
            `F5_CVT_IF:
              // opCtrl = {int->fp, 64 bit, signed}
              case (rs2)
                5'b00000: ctrl = 12'b1_0_01_00_101_0_0_0;  // from w
                5'b00001: ctrl = 12'b1_0_01_00_100_0_0_0;  // from wu
                5'b00010: ctrl = 12'b1_0_01_00_111_0_0_0;  // from l
                5'b00011: ctrl = 12'b1_0_01_00_110_0_0_0;  // from lu
                default:  ;
              endcase
            `F5_CVT_FI:
              case (rs2)
                5'b00000: ctrl = 12'b0_1_01_00_001_0_0_1;  // to w
                5'b00001: ctrl = 12'b0_1_01_00_000_0_0_1;  // to wu
                5'b00010: ctrl = 12'b0_1_01_00_011_0_0_1;  // to l
                5'b00011: ctrl = 12'b0_1_01_00_010_0_0_1;  // to lu
                default:  ;
              endcase
            default: ;
          endcase
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // rounding mode and precision
  assign frm = (funct3 == `RM_DYN) ? frmReg : funct3;
  assign fmt = isCvtFF ? rs2[0] : fmtField[0];  // cvt.fp.fp reads source fmt

  // trapped ops must not reach either regfile, writes are one-hot
  always_comb begin
    assert (!(ctrl.illegal && (ctrl.fRegWrite || ctrl.fWriteInt)))
      else $error("fpuDecoder: illegal instruction with a write enable");
    assert (!(ctrl.fRegWrite && ctrl.fWriteInt))
      else $error("fpuDecoder: fp and int write both set");
  end

endmodule

`default_nettype wire

// ==== fpuCtrl/operandEnables.sv ====
// operand enables
// marks which of X/Y/Z the op reads, so the unpacker
// ignores nan/inf on unused sources and hazards see real uses

`timescale 1ns/10ps
`default_nettype none

module operandEnables import fpuCtrlPkg::*; (
  input  decodeCtrl_t ctrl,
  output srcEn_t      srcEn
);

  logic isLoadStore;
  logic isLoadOrClass;
  logic isMvIntToFp;
  logic isMvFpToInt;
  logic isCvtIntToFp;
  logic isCvtOrSqrt;

  // resSel 10 without int write is fld/fsd, with int write it is fclass
  assign isLoadStore   = (ctrl.resSel == 2'b10) && !ctrl.fWriteInt;
  assign isLoadOrClass = (ctrl.resSel == 2'b10) && (ctrl.fWriteInt || ctrl.fRegWrite);

  // the sign-injection path with opCtrl 011 is fmv int->fp
  assign isMvIntToFp = (ctrl.resSel == 2'b00) && ctrl.fRegWrite &&
                       (ctrl.opCtrl == 3'b011);
  assign isMvFpToInt = (ctrl.resSel == 2'b11) && (ctrl.postProcSel == 2'b00);

  // cvt path, opCtrl[2] flags int source
  assign isCvtIntToFp = (ctrl.resSel == 2'b01) && (ctrl.postProcSel == 2'b00) &&
                        ctrl.opCtrl[2];
  assign isCvtOrSqrt  = (ctrl.resSel == 2'b01) &&
                        ((ctrl.postProcSel == 2'b00) ||
                         ((ctrl.postProcSel == 2'b01) && ctrl.opCtrl[0]));  // sqrt

  ////////////////////////////////////////////////////////////////////////////
  // enables
  assign srcEn.xEn = !(isLoadStore || isMvIntToFp || isCvtIntToFp);
  assign srcEn.yEn = !(isLoadOrClass || isMvIntToFp || isMvFpToInt || isCvtOrSqrt);

  // fma path: muladd family, add, sub. plain mul (100) has no addend
  assign srcEn.zEn = (ctrl.postProcSel == 2'b10) && (!ctrl.opCtrl[2] || ctrl.opCtrl[1]);

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/fpuCtrlPkg.sv
fpuCtrl/fpuDecoder.sv
fpuCtrl/operandEnables.sv
fpuCtrl/ctrlPipe.sv
src/fpuCtrl.sv
tests/fpuCtrlTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fpu control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f list.f --top-module fpuCtrlTb -Mdir obj_dir -o fpuCtrlSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fpuCtrlSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "All tests passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== src/fpuCtrl.sv ====
// fpu control unit top
// decodes one F/D instruction in D and carries its control
// through E, M and W alongside the integer pipeline

`timescale 1ns/10ps
`default_nettype none

module fpuCtrl import fpuCtrlPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] instr,        // decode-stage instruction
  input  roundMode_t  frmReg,
  input  logic [1:0]  fsStatus,
  input  pipeCtrl_t   pipe,
  input  logic        fdivBusyE,
  output logic        illegalInstrD,
  output regAddrs_t   regAddrD,
  output srcEn_t      srcEnD,
  output exCtrl_t     exCtrlE,
  output regAddrs_t   regAddrE,
  output srcEn_t      srcEnE,
  output logic        fdivStartE,
  output exCtrl_t     memCtrlM,
  output wbCtrl_t     wbCtrlW
);

  decodeCtrl_t ctrlD;
  roundMode_t  frmD;
  fpFmt_t      fmtD;

  // source register fields, rs3 only meaningful for fma
  assign regAddrD.adr1 = instr[19:15];
  assign regAddrD.adr2 = instr[24:20];
  assign regAddrD.adr3 = instr[31:27];

  fpuDecoder decoder (
    .instr    (instr),
    .frmReg   (frmReg),
    .fsStatus (fsStatus),
    .ctrl     (ctrlD),
    .frm      (frmD),
    .fmt      (fmtD)
  );

  assign illegalInstrD = ctrlD.illegal;  // to the trap logic

  operandEnables enables (
    .ctrl  (ctrlD),
    .srcEn (srcEnD)
  );

  ctrlPipe pipeRegs (
    .clk        (clk),
    .rst        (rst),
    .pipe       (pipe),
    .ctrlD      (ctrlD),
    .frmD       (frmD),
    .fmtD       (fmtD),
    .regAddrD   (regAddrD),
    .srcEnD     (srcEnD),
    .fdivBusyE  (fdivBusyE),
    .exCtrlE    (exCtrlE),
    .regAddrE   (regAddrE),
    .srcEnE     (srcEnE),
    .fdivStartE (fdivStartE),
    .memCtrlM   (memCtrlM),
    .wbCtrlW    (wbCtrlW)
  );

endmodule

`default_nettype wire

// ==== tests/fpuCtrlTb.sv ====
// fpu control testbench
// drives F/D instructions and pipeline controls into the control unit and
// checks decode, operand enables and stage timing against a reference model

`timescale 1ns/10ps
`default_nettype none

`include "fpuCtrl_consts.svh"

module fpuCtrlTb import fpuCtrlPkg::*; ();

  localparam int randOps   = 400;
  localparam int dirCycles = 70;     // reset plus directed part, rounded up
  localparam int timeoutNs = (randOps + dirCycles) * 4 + 400;
  localparam logic [1:0] fsOn = 2'b11;

  // stallE stallM stallW flushE flushM flushW
  localparam pipeCtrl_t runAll     = 6'b000000;
  localparam pipeCtrl_t holdE      = 6'b100000;
  localparam pipeCtrl_t clearE     = 6'b000100;
  localparam pipeCtrl_t holdClearE = 6'b100100;
  localparam pipeCtrl_t holdM      = 6'b010000;
  localparam pipeCtrl_t clearM     = 6'b000010;
  localparam pipeCtrl_t holdW      = 6'b001000;
  localparam pipeCtrl_t clearW     = 6'b000001;

  // expected stage contents, care bits mark what the rules pin down
  typedef struct packed {
    exCtrl_t   val;
    exCtrl_t   care;
    logic      div;
    regAddrs_t adr;
    srcEn_t    en;
    srcEn_t    enCare;
  } expect_t;

  logic        clk;
  logic        rst;
  logic [31:0] instr;
  roundMode_t  frmReg;
  logic [1:0]  fsStatus;
  pipeCtrl_t   pipe;
  logic        fdivBusyE;
  logic        illegalInstrD;
  regAddrs_t   regAddrD;
  srcEn_t      srcEnD;
  exCtrl_t     exCtrlE;
  regAddrs_t   regAddrE;
  srcEn_t      srcEnE;
  logic        fdivStartE;
  exCtrl_t     memCtrlM;
  wbCtrl_t     wbCtrlW;

  expect_t    stE, stM, stW, expD;
  logic       divE;                  // model of the divider start
  logic       checking = 1'b0;
  integer     seed;
  logic [6:0] fmaOpc [0:3] = '{`FP_OPC_MADD, `FP_OPC_MSUB, `FP_OPC_NMSUB, `FP_OPC_NMADD};

  fpuCtrl DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(timeoutNs);
    $display("watchdog: run did not finish within %0d ns, timed out", timeoutNs);
    $display("Some tests failed");
    $fatal(1, "timeout");
  end

  task automatic failCheck(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference rules
  function automatic expect_t clearedStage();
    expect_t e;
    e        = '0;
    e.care   = '1;   // flush and reset zero everything
    e.enCare = '1;
    return e;
  endfunction

  function automatic expect_t refDecode(logic [31:0] ins, roundMode_t frmR, logic [1:0] fs);
    expect_t    e;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [2:0] fmaOp;
    logic       bad;
    logic       hit;
    logic       isFma;
    opc   = ins[6:0];
    f3    = ins[14:12];
    fmaOp = {1'b0, opc[3:2]};    // madd..nmadd in opcode bits 3:2
    isFma = 1'b0;
    hit   = 1'b0;
    bad   = (fs == `FS_OFF) || (!(opc == `FP_OPC_LOAD || opc == `FP_OPC_STORE) &&
            (ins[26] || f3 == `RM_RSV5 || f3 == `RM_RSV6 ||
             (f3 == `RM_DYN && frmR >= 3'd5)));
    e     = '0;
    e.adr = {ins[19:15], ins[24:20], ins[31:27]};
    e.val.frm = (f3 == `RM_DYN) ? frmR : f3;
    e.val.fmt = ins[25];
    e.care.fRegWrite = 1'b1;   // always pinned, also on traps
    e.care.fWriteInt = 1'b1;
    e.care.frm       = '1;
    e.care.fmt       = 1'b1;
    e.care.cvtInt    = 1'b1;
    e.care.fpuActive = 1'b1;
    if (!bad) begin
      hit = 1'b1;
      case (opc)
        `FP_OPC_LOAD, `FP_OPC_STORE: begin
          hit = (f3 == `LS_WIDTH_W) || (f3 == `LS_WIDTH_D);
          e.val.fRegWrite = hit && (opc == `FP_OPC_LOAD);
          e.enCare.xEn    = hit;    // x unused
        end
        `FP_OPC_MADD, `FP_OPC_MSUB, `FP_OPC_NMSUB, `FP_OPC_NMADD: isFma = 1'b1;
        `FP_OPC_OP:
          case (ins[31:27])
            `F5_ADD: begin
              isFma = 1'b1;
              fmaOp = 3'b110;
            end
            `F5_SUB: begin
              isFma = 1'b1;
              fmaOp = 3'b111;
            end
            `F5_MUL: begin
              isFma = 1'b1;
              fmaOp = 3'b100;
            end
            `F5_DIV: begin
              e.val.fRegWrite   = 1'b1;
              e.val.postProcSel = 2'b01;
              e.care.postProcSel = '1;
              e.care.opCtrl[0]  = 1'b1;   // low for div
              e.div             = 1'b1;
              e.en              = 3'b110;
              e.enCare          = '1;
            end
            `F5_SQRT: begin
              hit               = (ins[24:20] == 5'd0);
              e.val.fRegWrite   = hit;
              e.val.postProcSel = hit ? 2'b01 : 2'b00;
              e.care.postProcSel = '1;
              e.div             = hit;
              e.enCare          = {1'b0, hit, hit};   // y and z unused
            end
            `F5_CMP: begin
              hit             = (f3 <= 3'd2);
              e.val.fWriteInt = hit;
              e.val.opCtrl    = (f3 == 3'd0) ? 3'b011 : (f3 == 3'd1) ? 3'b001 : 3'b010;
              e.care.opCtrl   = {3{hit}};
              e.care.resSel   = {2{hit}};    // resSel 00
              e.en            = 3'b110;
              e.enCare        = {3{hit}};
            end
            default: hit = 1'b0;
          endcase
        default: hit = 1'b0;
      endcase
    end
    if (isFma) begin
      e.val.fRegWrite   = 1'b1;
      e.val.resSel      = 2'b01;
      e.val.postProcSel = 2'b10;
      e.val.opCtrl      = fmaOp;
      e.care.resSel     = '1;
      e.care.postProcSel = '1;
      e.care.opCtrl     = '1;
      e.en              = {2'b11, fmaOp != 3'b100};   // plain mul has no addend
      e.enCare          = '1;
    end
    e.val.fpuActive = hit;
    return e;
  endfunction

  // stage record, same stall/flush the DUT sees
  always @(posedge clk) begin
    expect_t nxt;
    nxt = refDecode(instr, frmReg, fsStatus);
    if (rst) begin
      stE  <= clearedStage();
      stM  <= clearedStage();
      stW  <= clearedStage();
      divE <= 1'b0;
    end else begin
      if (!pipe.stallE)
        stE <= pipe.flushE ? clearedStage() : nxt;
      if (!pipe.stallE || fdivBusyE)
        divE <= pipe.flushE ? 1'b0 : nxt.div;
      if (!pipe.stallM)
        stM <= pipe.flushM ? clearedStage() : stE;
      if (!pipe.stallW)
        stW <= pipe.flushW ? clearedStage() : stM;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks, outputs sampled mid-cycle
  always @(negedge clk) begin
    if (checking) begin
      expD = refDecode(instr, frmReg, fsStatus);
      assert (illegalInstrD == !expD.val.fpuActive)
        else failCheck($sformatf("illegalInstrD %b for instr %h", illegalInstrD, instr));
      assert (regAddrD == expD.adr)
        else failCheck($sformatf("regAddrD %h, expected %h", regAddrD, expD.adr));
      assert (((srcEnD ^ expD.en) & expD.enCare) == 3'b000)
        else failCheck($sformatf("srcEnD %b for instr %h", srcEnD, instr));
      assert (((exCtrlE ^ stE.val) & stE.care) == '0)
        else failCheck($sformatf("exCtrlE %h, expected %h", exCtrlE, stE.val));
      assert (regAddrE == stE.adr)
        else failCheck($sformatf("regAddrE %h, expected %h", regAddrE, stE.adr));
      assert (((srcEnE ^ stE.en) & stE.enCare) == 3'b000)
        else failCheck($sformatf("srcEnE %b, expected %b", srcEnE, stE.en));
      assert (fdivStartE == divE)
        else failCheck($sformatf("fdivStartE %b, expected %b", fdivStartE, divE));
      assert (((memCtrlM ^ stM.val) & stM.care) == '0)
        else failCheck($sformatf("memCtrlM %h, expected %h", memCtrlM, stM.val));
      assert (wbCtrlW.fRegWrite == stW.val.fRegWrite && wbCtrlW.cvtInt == stW.val.cvtInt &&
              ((wbCtrlW.resSel ^ stW.val.resSel) & stW.care.resSel) == 2'b00)
        else failCheck($sformatf("wbCtrlW %h wrong", wbCtrlW));
    end
  end

  // idle divider and stalled E keep the start bit
  assert property (@(posedge clk) disable iff (rst)
                   (pipe.stallE && !fdivBusyE) |=> $stable(fdivStartE))
    else failCheck("fdivStartE changed with E stalled and divider idle");

  assert property (@(posedge clk) disable iff (rst) (fsStatus == `FS_OFF && !pipe.stallE)
                   |=> !exCtrlE.fpuActive && !exCtrlE.fRegWrite && !exCtrlE.fWriteInt)
    else failCheck("instruction decoded with FPU off is active in E");

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  function automatic logic [4:0] rnd5();
    logic [31:0] r;
    r = $random(seed);
    return r[4:0];
  endfunction

  // R/R4 layout, rs1 and rd random
  function automatic logic [31:0] encode(logic [4:0] f5, logic [1:0] fmtF, logic [4:0] rs2,
                                         logic [2:0] f3, logic [6:0] opc);
    logic [31:0] r;
    r = $random(seed);
    return {f5, fmtF, rs2, r[4:0], f3, r[9:5], opc};
  endfunction

  task automatic issue(input logic [31:0] ins, input logic [1:0] fs, input roundMode_t rm,
                       input pipeCtrl_t p, input logic busy);
    @(posedge clk);
    instr     <= ins;
    fsStatus  <= fs;
    frmReg    <= rm;
    pipe      <= p;
    fdivBusyE <= busy;
  endtask

  task automatic randomOp();
    logic [31:0] r;
    logic [31:0] r2;
    logic [4:0]  f5;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  opc;
    integer      kind;
    r    = $random(seed);
    r2   = $random(seed);
    kind = {28'd0, r[3:0]} % 11;
    f5   = rnd5();
    rs2  = rnd5();
    f3   = r2[6:4];
    opc  = `FP_OPC_OP;
    case (kind)
      0: begin
        opc = r2[0] ? `FP_OPC_LOAD : `FP_OPC_STORE;
        f3  = {2'b01, r2[1]};
      end
      1, 2, 3, 4: opc = fmaOpc[kind - 1];
      5: f5 = `F5_ADD;
      6: f5 = `F5_SUB;
      7: f5 = `F5_MUL;
      8: f5 = `F5_DIV;
      9: begin
        f5  = `F5_SQRT;
        rs2 = 5'd0;
      end
      default: begin
        f5 = `F5_CMP;
        f3 = (r2[3:2] == 2'b11) ? 3'b000 : {1'b0, r2[3:2]};
      end
    endcase
    issue(encode(f5, r[31:30], rs2, f3, opc), (r[25:22] == 4'd0) ? `FS_OFF : fsOn,
          r[28:26], {r[6:4] == 3'd0, r[9:7] == 3'd0, r[12:10] == 3'd0,
          r[15:13] == 3'd0, r[18:16] == 3'd0, r[21:19] == 3'd0}, r[29]);
  endtask

  initial begin
    seed      = 32'h15201a0e;
    rst       <= 1'b1;
    instr     <= '0;
    frmReg    <= '0;
    fsStatus  <= fsOn;
    pipe      <= runAll;
    fdivBusyE <= 1'b0;
    repeat (2) @(posedge clk);
    rst      <= 1'b0;
    checking = 1'b1;

    // fpu off, everything traps
    issue(encode(`F5_ADD, 2'b01, rnd5(), 3'b000, `FP_OPC_OP), `FS_OFF, 3'd0, runAll, 1'b0);
    issue(encode(rnd5(), 2'b00, rnd5(), 3'b000, `FP_OPC_MADD), `FS_OFF, 3'd0, runAll, 1'b0);

    // arithmetic table
    for (int i = 0; i < 4; i++)
      issue(encode(rnd5(), 2'b01, rnd5(), 3'b000, fmaOpc[i]), fsOn, 3'd0, runAll, 1'b0);
    issue(encode(`F5_MUL, 2'b00, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, runAll, 1'b0);
    issue(encode(`F5_ADD, 2'b01, rnd5(), 3'b001, `FP_OPC_OP), fsOn, 3'd0, runAll, 1'b0);
    issue(encode(`F5_SUB, 2'b00, rnd5(), 3'b010, `FP_OPC_OP), fsOn, 3'd0, runAll, 1'b0);
    issue(encode(`F5_DIV, 2'b01, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, runAll, 1'b0);
    for (int i = 0; i < 3; i++)  // fle flt feq
      issue(encode(`F5_CMP, 2'b01, rnd5(), 3'(i), `FP_OPC_OP), fsOn, 3'd0, runAll, 1'b0);

    // every rounding field, with a legal and a reserved frm
    for (int i = 0; i < 8; i++) begin
      issue(encode(`F5_ADD, 2'b01, rnd5(), 3'(i), `FP_OPC_OP), fsOn, 3'd2, runAll, 1'b0);
      issue(encode(`F5_ADD, 2'b00, rnd5(), 3'(i), `FP_OPC_OP), fsOn, 3'd6, runAll, 1'b0);
    end
    issue(encode(`F5_ADD, 2'b10, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, runAll, 1'b0);
    issue(encode(`F5_MUL, 2'b11, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, runAll, 1'b0);

    // enables
    issue(encode(rnd5(), 2'b11, rnd5(), 3'b011, `FP_OPC_LOAD), fsOn, 3'd0, runAll, 1'b0);
    issue(encode(`F5_SQRT, 2'b01, 5'd0, 3'b000, `FP_OPC_OP), fsOn, 3'd0, runAll, 1'b0);
    issue(encode(rnd5(), 2'b01, rnd5(), 3'b100, `FP_OPC_MADD), fsOn, 3'd0, runAll, 1'b0);

    // stall and flush per stage
    issue(encode(`F5_ADD, 2'b01, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, runAll, 1'b0);
    issue(encode(`F5_MUL, 2'b01, rnd5(), 3'b001, `FP_OPC_OP), fsOn, 3'd0, holdE, 1'b0);
    issue(encode(`F5_SUB, 2'b00, rnd5(), 3'b010, `FP_OPC_OP), fsOn, 3'd0, holdE, 1'b0);
    issue(encode(`F5_DIV, 2'b01, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, clearE, 1'b0);
    issue(encode(`F5_ADD, 2'b01, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, holdClearE, 1'b0);
    issue(encode(`F5_MUL, 2'b01, rnd5(), 3'b011, `FP_OPC_OP), fsOn, 3'd0, holdM, 1'b0);
    issue(encode(`F5_SUB, 2'b00, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, clearM, 1'b0);
    issue(encode(`F5_ADD, 2'b01, rnd5(), 3'b100, `FP_OPC_OP), fsOn, 3'd0, holdW, 1'b0);
    issue(encode(`F5_MUL, 2'b01, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, clearW, 1'b0);

    // divider start against busy
    issue(encode(`F5_DIV, 2'b01, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, runAll, 1'b0);
    issue(encode(`F5_ADD, 2'b01, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, holdE, 1'b1);
    issue(encode(`F5_DIV, 2'b00, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, holdE, 1'b1);
    issue(encode(`F5_ADD, 2'b01, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, holdE, 1'b0);

    for (int i = 0; i < randOps; i++)
      randomOp();

    repeat (4)   // drain to W
      issue(encode(`F5_ADD, 2'b01, rnd5(), 3'b000, `FP_OPC_OP), fsOn, 3'd0, runAll, 1'b0);
    @(posedge clk);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
